//--- filelist.f
verilog/cop_pkg.sv
verilog/cop_refresh_timer.sv
verilog/cop_rom_slot.sv
verilog/cop_bus_fsm.sv
verilog/cop_game.sv
verification/cop_clock_gen.sv
verification/cop_wb_mem.sv
verification/cop_game_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
    --top-module cop_game_tb -o cop_sim || exit 1
out=$(./obj_dir/cop_sim)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verification/cop_game_tb.sv
`timescale 1ns/1ps

module cop_game_tb;

    localparam logic [cop_pkg::bus_aw-1:0] main_base    = 22'h040000;
    localparam logic [cop_pkg::bus_aw-1:0] snd_base     = 22'h200000;
    localparam int                         rfsh_period  = 40;
    // Client word addresses stay below this so that repeats happen
    localparam logic [cop_pkg::bus_aw-1:0] addr_span    = 22'd8;
    localparam int                         n_req        = 60;
    // Other client's cycle, a refresh, own cycle, ok and the idle gap
    localparam int                         worst_cycles = 20;
    localparam int timeout_ns = (n_req * worst_cycles + rfsh_period) * 20;

    logic              clk24;
    logic              rst;
    cop_pkg::rom_req_t main_req;
    cop_pkg::rom_rsp_t main_rsp;
    cop_pkg::rom_req_t snd_req;
    cop_pkg::rom_rsp_t snd_rsp;
    cop_pkg::wb_m2s_t  wb_out;
    cop_pkg::wb_s2m_t  wb_in;
    logic              rfsh;

    integer seed;
    int     value_errs;
    int     protocol_errs;
    int     main_starts;
    int     snd_starts;
    int     cycle_n;
    int     last_rfsh;
    int     last_bank;
    bit     started;
    bit     seen_rfsh;
    bit     prev_cyc;
    bit     both_wait;

    cop_clock_gen clock_i (
        .clk24 ( clk24 ),
        .rst   ( rst   )
    );

    cop_wb_mem mem_i (
        .clk24 ( clk24  ),
        .rst   ( rst    ),
        .m2s   ( wb_out ),
        .s2m   ( wb_in  )
    );

    cop_game #(
        .main_base   ( main_base   ),
        .snd_base    ( snd_base    ),
        .rfsh_period ( rfsh_period )
    ) cop_game_i (
        .clk24    ( clk24    ),
        .rst      ( rst      ),
        .main_req ( main_req ),
        .main_rsp ( main_rsp ),
        .snd_req  ( snd_req  ),
        .snd_rsp  ( snd_rsp  ),
        .wb_out   ( wb_out   ),
        .wb_in    ( wb_in    ),
        .rfsh     ( rfsh     )
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("Error: %s is %h, expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic flag_protocol(input string what);
        protocol_errs++;
        $display("Protocol failure at %0t ns: %s", $time, what);
    endtask

    function automatic bit in_bank(input logic [cop_pkg::bus_aw-1:0] adr,
                                   input logic [cop_pkg::bus_aw-1:0] base);
        return (adr >= base) && (adr < base + addr_span);
    endfunction

    // One CPU port, holds cs and addr until ok
    task automatic run_client(input bit is_snd);
        logic [31:0]                rnd;
        logic [cop_pkg::bus_aw-1:0] addr;
        logic [cop_pkg::bus_aw-1:0] prev_addr;
        logic [cop_pkg::bus_aw-1:0] base;
        logic [cop_pkg::bus_dw-1:0] data;
        bit                         have_prev;
        bit                         ok;
        int                         starts0;
        int                         starts1;
        int                         gap;
        int                         i;
        string                      tag;

        base      = is_snd ? snd_base : main_base;
        tag       = is_snd ? "snd" : "main";
        have_prev = 1'b0;
        prev_addr = '0;
        for (i = 0; i < n_req; i++) begin
            rnd = $random(seed);
            if (have_prev && rnd[5:4] == 2'd0) begin
                addr = prev_addr;
            end else begin
                addr = {19'd0, rnd[2:0]};
            end
            @(posedge clk24);
            #2;
            starts0 = is_snd ? snd_starts : main_starts;
            if (is_snd) begin
                snd_req = '{cs: 1'b1, addr: addr};
            end else begin
                main_req = '{cs: 1'b1, addr: addr};
            end
            ok = 1'b0;
            while (!ok) begin
                @(negedge clk24);
                ok = is_snd ? snd_rsp.ok : main_rsp.ok;
            end
            data    = is_snd ? snd_rsp.data : main_rsp.data;
            starts1 = is_snd ? snd_starts : main_starts;
            check_value({tag, "_rsp.data"}, 32'(data), 32'(mem_i.word_at(base + addr)));
            // Repeat of the last word costs no bus cycle, a new word costs one
            check_value({tag, " bus cycles"}, 32'(starts1 - starts0),
                        (have_prev && addr == prev_addr) ? 32'd0 : 32'd1);
            prev_addr = addr;
            have_prev = 1'b1;
            gap       = int'(rnd[7:6]);
            if (gap != 0) begin
                @(posedge clk24);
                #2;
                if (is_snd) snd_req.cs = 1'b0;
                else main_req.cs = 1'b0;
                repeat (gap - 1) @(posedge clk24);
            end
        end
        @(posedge clk24);
        #2;
        if (is_snd) snd_req.cs = 1'b0;
        else main_req.cs = 1'b0;
    endtask

    // Bus and refresh monitor, sampled mid-cycle
    initial begin
        int bank;
        forever begin
            @(negedge clk24);
            if (!rst) begin
                cycle_n++;
                if (!started) begin
                    check_value("wb_out.cyc", 32'(wb_out.cyc), 32'd0);
                    check_value("wb_out.stb", 32'(wb_out.stb), 32'd0);
                    check_value("rfsh", 32'(rfsh), 32'd0);
                    check_value("main_rsp.ok", 32'(main_rsp.ok), 32'd0);
                    check_value("snd_rsp.ok", 32'(snd_rsp.ok), 32'd0);
                end
                if (rfsh) begin
                    if (wb_out.cyc) flag_protocol("refresh pulse while a bus cycle is open");
                    if (seen_rfsh && cycle_n - last_rfsh < rfsh_period)
                        flag_protocol($sformatf("refresh pulses only %0d cycles apart",
                                                cycle_n - last_rfsh));
                    if (cycle_n - last_rfsh > rfsh_period + 6)
                        flag_protocol($sformatf("no refresh for %0d cycles",
                                                cycle_n - last_rfsh));
                    last_rfsh = cycle_n;
                    seen_rfsh = 1'b1;
                end
                if (wb_out.cyc && !prev_cyc) begin
                    if (in_bank(wb_out.adr, main_base)) begin
                        bank = 0;
                        main_starts++;
                        check_value("wb_out.adr", 32'(wb_out.adr),
                                    32'(main_base + main_req.addr));
                    end else if (in_bank(wb_out.adr, snd_base)) begin
                        bank = 1;
                        snd_starts++;
                        check_value("wb_out.adr", 32'(wb_out.adr),
                                    32'(snd_base + snd_req.addr));
                    end else begin
                        bank = -1;
                        flag_protocol($sformatf("bus cycle at %h is outside both banks",
                                                wb_out.adr));
                    end
                    if (both_wait && bank >= 0 && bank == last_bank)
                        flag_protocol("same bank served twice while both clients waited");
                    last_bank = bank;
                end
                prev_cyc  = wb_out.cyc;
                both_wait = main_req.cs && !main_rsp.ok && snd_req.cs && !snd_rsp.ok;
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: requests still waiting for ok after %0d ns", timeout_ns);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        main_req      = '0;
        snd_req       = '0;
        seed          = 32'he25;
        value_errs    = 0;
        protocol_errs = 0;
        main_starts   = 0;
        snd_starts    = 0;
        cycle_n       = 0;
        last_rfsh     = 0;
        last_bank     = -1;
        started       = 1'b0;
        seen_rfsh     = 1'b0;
        prev_cyc      = 1'b0;
        both_wait     = 1'b0;
        wait (rst === 1'b0);
        repeat (3) @(posedge clk24);
        started = 1'b1;
        fork
            run_client(1'b0);
            run_client(1'b1);
        join
        repeat (8) @(posedge clk24);
        if (cycle_n - last_rfsh > rfsh_period + 6)
            flag_protocol("refresh stopped before the end of the run");
        $display("Summary: %0d value errors, %0d protocol errors", value_errs, protocol_errs);
        if (value_errs == 0 && protocol_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verification/cop_wb_mem.sv
`timescale 1ns/1ps

module cop_wb_mem (
    input  logic             clk24,
    input  logic             rst,
    input  cop_pkg::wb_m2s_t m2s,
    output cop_pkg::wb_s2m_t s2m
);

    logic [cop_pkg::bus_dw-1:0] words [0:1023];
    logic [1:0]                 wait_tab [0:255];
    logic [7:0]                 idx;
    logic [1:0]                 cnt;
    logic                       ack;
    logic [31:0]                fill;
    integer                     seed;

    // Random table, mixed with the upper address bits
    function automatic logic [cop_pkg::bus_dw-1:0] word_at(
        input logic [cop_pkg::bus_aw-1:0] adr
    );
        return words[adr[9:0]] ^ adr[21:6];
    endfunction

    initial begin
        seed = 32'he25;
        for (int i = 0; i < 1024; i++) begin
            fill     = $random(seed);
            words[i] = fill[15:0];
        end
        // Wait states for successive cycles, 0 to 3 each
        for (int i = 0; i < 256; i++) begin
            fill        = $random(seed);
            wait_tab[i] = fill[1:0];
        end
    end

    // Ack once the drawn number of wait states has passed
    assign ack = m2s.cyc && m2s.stb && (cnt == wait_tab[idx]);
    assign s2m = '{ack: ack, dat: ack ? word_at(m2s.adr) : '0};

    always @(posedge clk24) begin
        if (rst) begin
            cnt <= '0;
            idx <= '0;
        end else if (ack) begin
            cnt <= '0;
            idx <= idx + 1'b1;
        end else if (m2s.cyc && m2s.stb) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- verification/cop_clock_gen.sv
`timescale 1ns/1ps

module cop_clock_gen (
    output logic clk24,
    output logic rst
);

    // 20 ns period
    initial begin
        clk24 = 1'b0;
        forever #10 clk24 = ~clk24;
    end

    // Reset over the first 5 rising edges, released just after the last
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk24);
        #2;
        rst = 1'b0;
    end

endmodule

//--- verilog/cop_game.sv
`timescale 1ns/1ps

module cop_game #(
    parameter logic [cop_pkg::bus_aw-1:0] main_base   = 22'h000000,
    parameter logic [cop_pkg::bus_aw-1:0] snd_base    = 22'h080000,
    parameter int                         rfsh_period = 64
) (
    input  logic              clk24,
    input  logic              rst,
    // Main CPU ROM port
    input  cop_pkg::rom_req_t main_req,
    output cop_pkg::rom_rsp_t main_rsp,
    // Sound CPU ROM port
    input  cop_pkg::rom_req_t snd_req,
    output cop_pkg::rom_rsp_t snd_rsp,
    // External memory
    output cop_pkg::wb_m2s_t  wb_out,
    input  cop_pkg::wb_s2m_t  wb_in,
    output logic              rfsh
);

    logic                       main_miss;
    logic                       snd_miss;
    logic [cop_pkg::bus_aw-1:0] main_adr;
    logic [cop_pkg::bus_aw-1:0] snd_adr;
    logic                       main_done;
    logic                       snd_done;
    logic                       done;
    logic                       due;
    logic                       rfsh_taken;
    cop_pkg::client_e           grant;

    // Completion goes only to the slot that owns the cycle
    assign main_done = done && (grant == cop_pkg::client_main);
    assign snd_done  = done && (grant == cop_pkg::client_snd);

    cop_rom_slot #(
        .bank_base ( main_base )
    ) u_main_slot (
        .clk24     ( clk24     ),
        .rst       ( rst       ),
        .req_in    ( main_req  ),
        .rsp       ( main_rsp  ),
        .req       ( main_miss ),
        .bus_adr   ( main_adr  ),
        .done      ( main_done ),
        .bus_dat   ( wb_in.dat )
    );

    cop_rom_slot #(
        .bank_base ( snd_base  )
    ) u_snd_slot (
        .clk24     ( clk24     ),
        .rst       ( rst       ),
        .req_in    ( snd_req   ),
        .rsp       ( snd_rsp   ),
        .req       ( snd_miss  ),
        .bus_adr   ( snd_adr   ),
        .done      ( snd_done  ),
        .bus_dat   ( wb_in.dat )
    );

    cop_bus_fsm u_bus (
        .clk24      ( clk24      ),
        .rst        ( rst        ),
        .main_req   ( main_miss  ),
        .snd_req    ( snd_miss   ),
        .main_adr   ( main_adr   ),
        .snd_adr    ( snd_adr    ),
        .due        ( due        ),
        .wb_out     ( wb_out     ),
        .wb_in      ( wb_in      ),
        .grant      ( grant      ),
        .done       ( done       ),
        .rfsh_taken ( rfsh_taken ),
        .rfsh       ( rfsh       )
    );

    cop_refresh_timer #(
        .rfsh_period ( rfsh_period )
    ) u_rfsh (
        .clk24      ( clk24      ),
        .rst        ( rst        ),
        .rfsh_taken ( rfsh_taken ),
        .due        ( due        )
    );

endmodule

//--- verilog/cop_bus_fsm.sv
`timescale 1ns/1ps

module cop_bus_fsm (
    input  logic                       clk24,
    input  logic                       rst,
    input  logic                       main_req,
    input  logic                       snd_req,
    input  logic [cop_pkg::bus_aw-1:0] main_adr,
    input  logic [cop_pkg::bus_aw-1:0] snd_adr,
    input  logic                       due,
    output cop_pkg::wb_m2s_t           wb_out,
    input  cop_pkg::wb_s2m_t           wb_in,
    output cop_pkg::client_e           grant,
    output logic                       done,
    output logic                       rfsh_taken,
    output logic                       rfsh
);

    cop_pkg::bus_state_e        state;
    cop_pkg::client_e           last_served;
    cop_pkg::client_e           pick;
    logic                       any_req;
    logic                       launch;
    logic                       cyc_q;
    logic                       stb_q;
    logic [cop_pkg::bus_aw-1:0] adr_q;

    // Round robin, the client not served last wins a tie
    always_comb begin
        any_req = main_req || snd_req;
        if (main_req && snd_req) begin
            if (last_served == cop_pkg::client_main) begin
                pick = cop_pkg::client_snd;
            end else begin
                pick = cop_pkg::client_main;
            end
        end else if (snd_req) begin
            pick = cop_pkg::client_snd;
        end else begin
            pick = cop_pkg::client_main;
        end
    end

    // Refresh has priority over a client fetch
    assign launch = (state == cop_pkg::bus_idle) && !due && any_req;

    always_ff @(posedge clk24) begin
        if (rst) begin
            state       <= cop_pkg::bus_idle;
            grant       <= cop_pkg::client_main;
            last_served <= cop_pkg::client_snd;
            cyc_q       <= 1'b0;
            stb_q       <= 1'b0;
        end else begin
            case (state)
                cop_pkg::bus_idle: begin
                    if (due) begin
                        state <= cop_pkg::bus_rfsh;
                    end else if (any_req) begin
                        state <= cop_pkg::bus_cycle;
                        grant <= pick;
                        cyc_q <= 1'b1;
                        stb_q <= 1'b1;
                    end
                end
                cop_pkg::bus_cycle: begin
                    if (wb_in.ack) begin
                        state       <= cop_pkg::bus_idle;
                        last_served <= grant;
                        cyc_q       <= 1'b0;
                        stb_q       <= 1'b0;
                    end
                end
                cop_pkg::bus_rfsh: begin
                    state <= cop_pkg::bus_idle;
                end
                default: begin
                    state <= cop_pkg::bus_idle;
                end
            endcase
        end
    end

    // Winner's address is latched for the whole cycle
    always_ff @(posedge clk24) begin
        if (launch) begin
            adr_q <= (pick == cop_pkg::client_snd) ? snd_adr : main_adr;
        end
    end

    assign wb_out = '{cyc: cyc_q, stb: stb_q, adr: adr_q};

    // Slot captures dat on this edge
    assign done = (state == cop_pkg::bus_cycle) && wb_in.ack;

    // One cycle refresh slot, timer restarts from here
    assign rfsh       = (state == cop_pkg::bus_rfsh);
    assign rfsh_taken = (state == cop_pkg::bus_rfsh);

    a_stb_in_cyc: assert property (
        @(posedge clk24) disable iff (rst)
        wb_out.stb |-> wb_out.cyc
    );

    a_rfsh_no_cyc: assert property (
        @(posedge clk24) disable iff (rst)
        !(rfsh && wb_out.cyc)
    );

    a_adr_stable: assert property (
        @(posedge clk24) disable iff (rst)
        wb_out.cyc && !wb_in.ack |=> wb_out.cyc && $stable(wb_out.adr)
    );

endmodule

//--- verilog/cop_rom_slot.sv
`timescale 1ns/1ps

module cop_rom_slot #(
    parameter logic [cop_pkg::bus_aw-1:0] bank_base = '0
) (
    input  logic                       clk24,
    input  logic                       rst,
    input  cop_pkg::rom_req_t          req_in,
    output cop_pkg::rom_rsp_t          rsp,
    output logic                       req,
    output logic [cop_pkg::bus_aw-1:0] bus_adr,
    input  logic                       done,
    input  logic [cop_pkg::bus_dw-1:0] bus_dat
);

    logic                       valid;
    logic                       pending;
    logic                       hit;
    logic                       start;
    logic [cop_pkg::bus_aw-1:0] fetch_addr;
    logic [cop_pkg::bus_aw-1:0] last_addr;
    logic [cop_pkg::bus_dw-1:0] last_data;

    // Last fetched word answers repeats without a bus access
    assign hit = valid && (last_addr == req_in.addr);

    // A fetch, once requested, is carried through to the end
    assign start = req_in.cs && !hit && !pending;
    assign req   = pending || (req_in.cs && !hit);

    // Address is frozen while the fetch is outstanding
    assign bus_adr = bank_base + (pending ? fetch_addr : req_in.addr);

    assign rsp = '{
        ok:   req_in.cs && hit && !pending,
        data: last_data
    };

    always_ff @(posedge clk24) begin
        if (rst) begin
            valid   <= 1'b0;
            pending <= 1'b0;
        end else if (done) begin
            valid   <= 1'b1;
            pending <= 1'b0;
        end else if (start) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk24) begin
        if (start) begin
            fetch_addr <= req_in.addr;
        end
        if (done) begin
            last_addr <= fetch_addr;
            last_data <= bus_dat;
        end
    end

    a_ok_needs_cs: assert property (
        @(posedge clk24) disable iff (rst)
        rsp.ok |-> req_in.cs
    );

    a_req_ok_excl: assert property (
        @(posedge clk24) disable iff (rst)
        !(req && rsp.ok)
    );

    // The scheduler only completes a fetch this slot has asked for
    a_done_pending: assert property (
        @(posedge clk24) disable iff (rst)
        done |-> pending
    );

endmodule

//--- verilog/cop_refresh_timer.sv
`timescale 1ns/1ps

module cop_refresh_timer #(
    parameter int rfsh_period = 64
) (
    input  logic clk24,
    input  logic rst,
    input  logic rfsh_taken,
    output logic due
);

    localparam int cnt_w = $clog2(rfsh_period + 1);

    logic [cnt_w-1:0] cnt;

    // Counts up to the period, then parks with due set
    always_ff @(posedge clk24) begin
        if (rst || rfsh_taken) begin
            cnt <= '0;
            due <= 1'b0;
        end else if (!due) begin
            cnt <= cnt + 1'b1;
            if (cnt == cnt_w'(rfsh_period - 1)) begin
                due <= 1'b1;
            end
        end
    end

    // Scheduler only takes a refresh that was requested
    a_taken_when_due: assert property (
        @(posedge clk24) disable iff (rst)
        rfsh_taken |-> due
    );

endmodule

//--- verilog/cop_pkg.sv
package cop_pkg;

    // External ROM bus widths, in 16-bit words
    localparam int bus_aw = 22;
    localparam int bus_dw = 16;

    // CPU side ROM port, cs/addr in and ok/data back
    typedef struct packed {
        logic              cs;
        logic [bus_aw-1:0] addr;
    } rom_req_t;

    typedef struct packed {
        logic              ok;
        logic [bus_dw-1:0] data;
    } rom_rsp_t;

    // Wishbone classic, read only
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic [bus_aw-1:0] adr;
    } wb_m2s_t;

    typedef struct packed {
        logic              ack;
        logic [bus_dw-1:0] dat;
    } wb_s2m_t;

    // Bus scheduler states
    typedef enum logic [1:0] {
        bus_idle  = 2'd0,
        bus_cycle = 2'd1,
        bus_rfsh  = 2'd2
    } bus_state_e;

    // Owner of the current bus cycle
    typedef enum logic {
        client_main = 1'b0,
        client_snd  = 1'b1
    } client_e;

endpackage
